//--- flist.f
logic/fetch_pkg.sv
logic/predict_pkg.sv
logic/fetch_pc.sv
logic/branch_predict.sv
logic/fetch_steer.sv
logic/fetch_unit.sv
dv/fetch_unit_tb.sv

//--- Bender.yml
package:
  name: fetch_unit

sources:
  # packages first, then the blocks, then the top level
  - logic/fetch_pkg.sv
  - logic/predict_pkg.sv
  - logic/fetch_pc.sv
  - logic/branch_predict.sv
  - logic/fetch_steer.sv
  - logic/fetch_unit.sv

  # testbench, top module fetch_unit_tb
  - target: test
    files:
      - dv/fetch_unit_tb.sv

//--- dv/fetch_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

// testbench for the 2-wide fetch front end
// a reference model of pc, counters and target buffer runs beside the DUT
module fetch_unit_tb
  import fetch_pkg::*;
();

  localparam addr_t       start_pc        = 64'h100;
  localparam int unsigned bht_bits        = 6;
  localparam int unsigned btb_bits        = 4;
  localparam int          reset_cycles    = 8;
  localparam int          directed_cycles = 80;  // bound on the directed part
  localparam int          random_cycles   = 400;
  localparam int          margin_cycles   = 50;
  localparam int          clock_period    = 20;  // ns

  logic                  clock;
  logic                  reset;
  logic                  get_next_inst;
  fetch_word_t           imem_data;
  logic                  imem_valid;
  addr_t                 imem_addr;
  logic                  rollback_en;
  addr_t                 rollback_pc;
  logic                  resolve_valid;
  addr_t                 resolve_pc;
  logic                  resolve_taken;
  addr_t                 resolve_target;
  addr_t [num_slots-1:0] slot_pc;
  addr_t [num_slots-1:0] slot_npc;
  addr_t [num_slots-1:0] slot_target;
  inst_t [num_slots-1:0] slot_ir;
  slot_vec_t             slot_valid;

  integer seed;
  int     errors  = 0;
  int     checked = 0;  // cycles looked at by the assertions
  string  test_name;

  //////////////////////////////
  // reference model
  //////////////////////////////

  addr_t                 m_pc;
  logic [1:0]            m_ctr        [2**bht_bits]; // bimodal counters
  logic                  m_btb_valid  [2**btb_bits];
  addr_t                 m_btb_tag    [2**btb_bits];
  addr_t                 m_btb_target [2**btb_bits];
  logic [bht_bits-1:0]   r_bht;                      // training indices
  logic [btb_bits-1:0]   r_btb;
  addr_t                 exp_addr;
  addr_t                 exp_next;
  addr_t [num_slots-1:0] exp_pc;
  addr_t [num_slots-1:0] exp_npc;
  addr_t [num_slots-1:0] exp_target;
  inst_t [num_slots-1:0] exp_ir;
  slot_vec_t             exp_valid;
  slot_vec_t             exp_hit;                    // counter taken and tag match

  // memory contents, a pattern over the whole address
  function automatic inst_t inst_at(input addr_t a);
    return a[31:0] ^ a[63:32] ^ 32'h5a3c_96e1;
  endfunction

  assign imem_data = {inst_at(imem_addr + 64'd4), inst_at(imem_addr)}; // low half first
  assign r_bht     = resolve_pc[2 +: bht_bits];
  assign r_btb     = resolve_pc[2 +: btb_bits];

  always_comb
  begin
    exp_addr  = {m_pc[63:3], 3'b000};
    exp_pc[0] = m_pc;
    exp_pc[1] = m_pc[2] ? m_pc : m_pc + 64'd4; // odd word, both slots at m_pc
    for (int s = 0; s < num_slots; s++)
    begin
      exp_npc[s] = exp_pc[s] + 64'd4;
      exp_hit[s] = m_ctr[exp_pc[s][2 +: bht_bits]][1] && m_btb_valid[exp_pc[s][2 +: btb_bits]]
                   && (m_btb_tag[exp_pc[s][2 +: btb_bits]] == (exp_pc[s] >> (2 + btb_bits)));
    end
    exp_valid[0] = imem_valid && !m_pc[2];
    exp_valid[1] = imem_valid && !(exp_valid[0] && exp_hit[0]); // squash behind taken slot 0
    exp_next     = m_pc + (m_pc[2] ? 64'd4 : 64'd8);
    for (int s = num_slots - 1; s >= 0; s--)
    begin
      exp_target[s] = exp_npc[s];
      if (exp_valid[s] && exp_hit[s])
      begin
        exp_target[s] = m_btb_target[exp_pc[s][2 +: btb_bits]];
        exp_next      = exp_target[s]; // slot 0 comes last, so it wins
      end
      exp_ir[s] = exp_valid[s] ? inst_at(exp_pc[s]) : noop_inst;
    end
  end

  always @(posedge clock)
  begin
    if (reset)
    begin
      m_pc <= start_pc;
      for (int i = 0; i < 2**bht_bits; i++)
        m_ctr[i] <= 2'b01;       // weakly not taken
      for (int i = 0; i < 2**btb_bits; i++)
        m_btb_valid[i] <= 1'b0;
    end
    else
    begin
      if (rollback_en)
        m_pc <= rollback_pc;
      else if (imem_valid && get_next_inst)
        m_pc <= exp_next;
      if (resolve_valid)
      begin
        if (resolve_taken && m_ctr[r_bht] != 2'b11)
          m_ctr[r_bht] <= m_ctr[r_bht] + 2'd1;
        else if (!resolve_taken && m_ctr[r_bht] != 2'b00)
          m_ctr[r_bht] <= m_ctr[r_bht] - 2'd1;
        if (resolve_taken)
        begin
          m_btb_valid[r_btb]  <= 1'b1;
          m_btb_tag[r_btb]    <= resolve_pc >> (2 + btb_bits);
          m_btb_target[r_btb] <= resolve_target;
        end
      end
    end
  end

  //////////////////////////////
  // DUT and checks
  //////////////////////////////

  fetch_unit #(
    .reset_pc       (start_pc),
    .bht_index_bits (bht_bits),
    .btb_index_bits (btb_bits)
  ) i_fetch_unit (
    .clock          (clock),
    .reset          (reset),
    .get_next_inst  (get_next_inst),
    .imem_data      (imem_data),
    .imem_valid     (imem_valid),
    .imem_addr      (imem_addr),
    .rollback_en    (rollback_en),
    .rollback_pc    (rollback_pc),
    .resolve_valid  (resolve_valid),
    .resolve_pc     (resolve_pc),
    .resolve_taken  (resolve_taken),
    .resolve_target (resolve_target),
    .slot_pc        (slot_pc),
    .slot_npc       (slot_npc),
    .slot_ir        (slot_ir),
    .slot_target    (slot_target),
    .slot_valid     (slot_valid)
  );

  task automatic report_mismatch(input string what, input logic [127:0] exp,
                                 input logic [127:0] act);
    errors++;
    $display("Mismatch %s %s: expected %0h actual %0h", test_name, what, exp, act);
  endtask

  always @(posedge clock)
    if (!reset)
      checked++;

  addr_check: assert property (@(posedge clock) disable iff (reset) imem_addr == exp_addr)
    else report_mismatch("imem_addr", 128'($sampled(exp_addr)), 128'($sampled(imem_addr)));
  pc_check: assert property (@(posedge clock) disable iff (reset) slot_pc == exp_pc)
    else report_mismatch("slot_pc", $sampled(exp_pc), $sampled(slot_pc));
  npc_check: assert property (@(posedge clock) disable iff (reset) slot_npc == exp_npc)
    else report_mismatch("slot_npc", $sampled(exp_npc), $sampled(slot_npc));
  valid_check: assert property (@(posedge clock) disable iff (reset) slot_valid == exp_valid)
    else report_mismatch("slot_valid", 128'($sampled(exp_valid)), 128'($sampled(slot_valid)));
  ir_check: assert property (@(posedge clock) disable iff (reset) slot_ir == exp_ir)
    else report_mismatch("slot_ir", 128'($sampled(exp_ir)), 128'($sampled(slot_ir)));
  target_check: assert property (@(posedge clock) disable iff (reset) slot_target == exp_target)
    else report_mismatch("slot_target", $sampled(exp_target), $sampled(slot_target));

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial
  begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  // watchdog sized from the test lengths
  initial
  begin
    #(clock_period * (reset_cycles + directed_cycles + random_cycles + margin_cycles));
    $display("timeout: the stimulus did not finish, run stopped by the watchdog");
    $display("RESULT: FAIL");
    $finish;
  end

  // tasks are entered and left on a falling edge
  task automatic rollback_to(input addr_t pc);
    rollback_en = 1'b1;
    rollback_pc = pc;
    @(negedge clock);
    rollback_en = 1'b0;
  endtask

  task automatic train(input addr_t pc, input logic taken, input addr_t target);
    resolve_valid  = 1'b1;
    resolve_pc     = pc;
    resolve_taken  = taken;
    resolve_target = target;
    @(negedge clock);
    resolve_valid = 1'b0;
  endtask

  task automatic run_random(input int cycles);
    logic [31:0] rnd;
    logic [31:0] rnd2;
    for (int i = 0; i < cycles; i++)
    begin
      rnd            = $random(seed);
      rnd2           = $random(seed);
      get_next_inst  = rnd[0];
      imem_valid     = rnd[2:1] != 2'b00;  // about three quarters
      rollback_en    = rnd[6:3] == 4'h0;   // rare redirect
      rollback_pc    = {54'b0, rnd[14:7], 2'b00};
      resolve_valid  = rnd[16:15] == 2'b00;
      resolve_taken  = rnd[17];
      resolve_pc     = {54'b0, rnd2[7:0], 2'b00};
      resolve_target = {54'b0, rnd2[15:8], 2'b00};
      @(negedge clock);
    end
    rollback_en   = 1'b0;
    resolve_valid = 1'b0;
  endtask

  initial
  begin
    seed = 32'h68243036;
    reset = 1'b1;
    {get_next_inst, imem_valid, rollback_en, resolve_valid, resolve_taken} = '0;
    {rollback_pc, resolve_pc, resolve_target} = '0;
    test_name = "reset";
    repeat (reset_cycles) @(negedge clock);
    reset = 1'b0;

    test_name     = "sequential";
    imem_valid    = 1'b1;
    get_next_inst = 1'b1;
    repeat (10) @(negedge clock);

    test_name     = "stall";
    get_next_inst = 1'b0;  // same group again
    repeat (3) @(negedge clock);
    get_next_inst = 1'b1;
    imem_valid    = 1'b0;  // nops in both slots
    repeat (3) @(negedge clock);
    imem_valid = 1'b1;
    rollback_to(64'h104);  // odd word, half step
    repeat (3) @(negedge clock);

    test_name     = "rollback_stalled";
    get_next_inst = 1'b0;
    rollback_to(64'h40);
    repeat (2) @(negedge clock);
    get_next_inst = 1'b1;

    test_name = "taken_slot0";
    train(64'h200, 1'b1, 64'h3a0);
    train(64'h200, 1'b1, 64'h3a0);
    rollback_to(64'h200);
    repeat (3) @(negedge clock);

    test_name = "rollback_over_redirect";
    rollback_to(64'h200);
    rollback_to(64'h80);   // same edge as the predicted redirect
    repeat (2) @(negedge clock);

    test_name = "taken_slot1";
    train(64'h30c, 1'b1, 64'h1f0);
    train(64'h30c, 1'b1, 64'h1f0);
    rollback_to(64'h308);
    repeat (3) @(negedge clock);

    test_name = "alias";   // same indices as 0x200, other tag
    rollback_to(64'h300);
    repeat (2) @(negedge clock);

    test_name = "train_back";
    train(64'h200, 1'b0, 64'h0);
    train(64'h200, 1'b0, 64'h0);
    rollback_to(64'h200);
    repeat (3) @(negedge clock);

    test_name = "random";
    run_random(random_cycles);
    @(negedge clock);

    $display("checked %0d cycles, %0d errors", checked, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

// instruction fetch front end, 2 slots per group
// pc and predictor look at the same pc, steer merges their results
module fetch_unit
  import fetch_pkg::*;
#(
  parameter addr_t       reset_pc       = '0,
  parameter int unsigned bht_index_bits = 6,
  parameter int unsigned btb_index_bits = 4
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  get_next_inst,  // back end ready for a group
  // instruction memory
  input  fetch_word_t           imem_data,
  input  logic                  imem_valid,     // combinational from imem_addr
  output addr_t                 imem_addr,
  // back end redirect
  input  logic                  rollback_en,
  input  addr_t                 rollback_pc,
  // branch resolution
  input  logic                  resolve_valid,
  input  addr_t                 resolve_pc,
  input  logic                  resolve_taken,
  input  addr_t                 resolve_target,
  // fetch group to decode
  output addr_t [num_slots-1:0] slot_pc,
  output addr_t [num_slots-1:0] slot_npc,
  output inst_t [num_slots-1:0] slot_ir,
  output addr_t [num_slots-1:0] slot_target,
  output slot_vec_t             slot_valid
);

  addr_t                 cur_pc;
  addr_t                 seq_pc;
  slot_vec_t             raw_valid;   // before squash
  slot_vec_t             pred_taken;
  addr_t [num_slots-1:0] pred_target;
  addr_t                 next_pc;     // loops back into the pc register

  ///////////////////////////////
  // pc and addresses
  ///////////////////////////////

  fetch_pc #(
    .reset_pc      (reset_pc)
  ) i_fetch_pc (
    .clock         (clock),
    .reset         (reset),
    .get_next_inst (get_next_inst),
    .imem_valid    (imem_valid),
    .rollback_en   (rollback_en),
    .rollback_pc   (rollback_pc),
    .next_pc       (next_pc),
    .imem_addr     (imem_addr),
    .cur_pc        (cur_pc),
    .slot_pc       (slot_pc),
    .slot_npc      (slot_npc),
    .seq_pc        (seq_pc),
    .raw_valid     (raw_valid)
  );

  ///////////////////////////////
  // prediction, same cycle
  ///////////////////////////////

  branch_predict #(
    .bht_index_bits (bht_index_bits),
    .btb_index_bits (btb_index_bits)
  ) i_branch_predict (
    .clock          (clock),
    .reset          (reset),
    .slot_pc        (slot_pc),
    .resolve_valid  (resolve_valid),
    .resolve_pc     (resolve_pc),
    .resolve_taken  (resolve_taken),
    .resolve_target (resolve_target),
    .pred_taken     (pred_taken),
    .pred_target    (pred_target)
  );

  fetch_steer i_fetch_steer (
    .imem_data   (imem_data),
    .cur_pc      (cur_pc),
    .slot_npc    (slot_npc),
    .seq_pc      (seq_pc),
    .raw_valid   (raw_valid),
    .pred_taken  (pred_taken),
    .pred_target (pred_target),
    .slot_ir     (slot_ir),
    .slot_target (slot_target),
    .slot_valid  (slot_valid),
    .next_pc     (next_pc)
  );

endmodule

`default_nettype wire

//--- logic/fetch_steer.sv
`timescale 1ns/1ps
`default_nettype none

// merges raw slot validity with predictions
// picks the redirect, fills slot targets and splits the memory word
module fetch_steer
  import fetch_pkg::*;
(
  input  fetch_word_t           imem_data,   // two instruction words
  input  addr_t                 cur_pc,      // pc of the group
  input  addr_t [num_slots-1:0] slot_npc,    // fall through per slot
  input  addr_t                 seq_pc,      // next group when nothing is taken
  input  slot_vec_t             raw_valid,
  input  slot_vec_t             pred_taken,
  input  addr_t [num_slots-1:0] pred_target,
  output inst_t [num_slots-1:0] slot_ir,
  output addr_t [num_slots-1:0] slot_target,
  output slot_vec_t             slot_valid,
  output addr_t                 next_pc      // to fetch_pc
);

  inst_t [num_slots-1:0] mem_words;  // imem_data cut into instructions
  inst_t [num_slots-1:0] slot_word;  // word each slot would carry
  slot_vec_t             slot_taken; // valid and predicted taken

  //////////////////////////////
  // validity and squash
  //////////////////////////////

  assign slot_valid[0] = raw_valid[0];
  // a taken slot 0 leaves slot 1 on the wrong path
  assign slot_valid[1] = raw_valid[1] && !(raw_valid[0] && pred_taken[0]);

  assign slot_taken = slot_valid & pred_taken;

  //////////////////////////////
  // targets and redirect
  //////////////////////////////

  always_comb
  begin
    for (int s = 0; s < num_slots; s++)
      slot_target[s] = slot_taken[s] ? pred_target[s] : slot_npc[s];
  end

  // first taken slot wins
  always_comb
  begin
    if (slot_taken[0])
      next_pc = pred_target[0];
    else if (slot_taken[1])
      next_pc = pred_target[1];
    else
      next_pc = seq_pc;          // sequential, full or half step
  end

  //////////////////////////////
  // instruction words
  //////////////////////////////

  assign mem_words = imem_data; // low half is the lower address

  // slot 0 reads the half the pc points at, slot 1 always the upper half
  assign slot_word[0] = mem_words[cur_pc[slot_sel_bit]];
  assign slot_word[1] = mem_words[num_slots-1];

  always_comb
  begin
    for (int s = 0; s < num_slots; s++)
      slot_ir[s] = slot_valid[s] ? slot_word[s] : noop_inst; // nop fill
  end

endmodule

`default_nettype wire

//--- logic/branch_predict.sv
`timescale 1ns/1ps
`default_nettype none

// bimodal direction table plus tagged target buffer
// two read ports (one per slot), one training port from the back end
module branch_predict
  import fetch_pkg::*;
  import predict_pkg::*;
#(
  parameter int unsigned bht_index_bits = 6, // log2 counter entries
  parameter int unsigned btb_index_bits = 4  // log2 buffer entries
) (
  input  logic                  clock,
  input  logic                  reset,
  input  addr_t [num_slots-1:0] slot_pc,        // lookup addresses
  input  logic                  resolve_valid,  // one resolved branch
  input  addr_t                 resolve_pc,
  input  logic                  resolve_taken,
  input  addr_t                 resolve_target,
  output slot_vec_t             pred_taken,     // per slot direction and hit
  output addr_t [num_slots-1:0] pred_target
);

  localparam int unsigned bht_entries = 2 ** bht_index_bits;
  localparam int unsigned btb_entries = 2 ** btb_index_bits;
  localparam int unsigned tag_lsb     = pc_index_lsb + btb_index_bits; // first tag bit

  typedef logic [bht_index_bits-1:0] bht_idx_t;
  typedef logic [btb_index_bits-1:0] btb_idx_t;

  ctr_t       bht [bht_entries]; // direction counters
  btb_entry_t btb [btb_entries]; // targets

  //////////////////////////////
  // address slicing
  //////////////////////////////

  function automatic bht_idx_t bht_index(input addr_t pc);
    return pc[pc_index_lsb +: bht_index_bits];
  endfunction

  function automatic btb_idx_t btb_index(input addr_t pc);
    return pc[pc_index_lsb +: btb_index_bits];
  endfunction

  // everything above the buffer index, shifted down
  function automatic addr_t btb_tag(input addr_t pc);
    return pc >> tag_lsb;
  endfunction

  //////////////////////////////
  // lookup ports
  //////////////////////////////

  ctr_t       [num_slots-1:0] rd_ctr;  // counter read per slot
  btb_entry_t [num_slots-1:0] rd_ent;  // buffer entry read per slot
  slot_vec_t                  tag_hit; // valid entry with matching tag

  always_comb
  begin
    for (int s = 0; s < num_slots; s++)
    begin
      rd_ctr[s]  = bht[bht_index(slot_pc[s])];
      rd_ent[s]  = btb[btb_index(slot_pc[s])];
      tag_hit[s] = rd_ent[s].valid && (rd_ent[s].tag == btb_tag(slot_pc[s]));
      // no target means no redirect, whatever the counter says
      pred_taken[s]  = rd_ctr[s][ctr_taken_bit] && tag_hit[s];
      pred_target[s] = rd_ent[s].target;
    end
  end

  //////////////////////////////
  // training port
  //////////////////////////////

  bht_idx_t   wr_bht_idx;
  btb_idx_t   wr_btb_idx;
  ctr_t       wr_ctr_old; // counter before the update
  ctr_t       wr_ctr_new; // one step toward the outcome
  btb_entry_t wr_entry;

  assign wr_bht_idx = bht_index(resolve_pc);
  assign wr_btb_idx = btb_index(resolve_pc);
  assign wr_ctr_old = bht[wr_bht_idx];

  // saturating step
  always_comb
  begin
    wr_ctr_new = wr_ctr_old;
    if (resolve_taken)
    begin
      if (wr_ctr_old != ctr_strong_t)
        wr_ctr_new = wr_ctr_old + 2'd1;
    end
    else if (wr_ctr_old != ctr_strong_nt)
    begin
      wr_ctr_new = wr_ctr_old - 2'd1;
    end
  end

  assign wr_entry.valid  = 1'b1;
  assign wr_entry.tag    = btb_tag(resolve_pc);
  assign wr_entry.target = resolve_target;

  // written this edge, seen by lookups next cycle
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      for (int i = 0; i < bht_entries; i++)
        bht[i] <= ctr_weak_nt; // all weakly not taken
      for (int i = 0; i < btb_entries; i++)
        btb[i] <= '0;          // all invalid
    end
    else if (resolve_valid)
    begin
      bht[wr_bht_idx] <= wr_ctr_new;
      if (resolve_taken)
        btb[wr_btb_idx] <= wr_entry; // not taken leaves the target alone
    end
  end

endmodule

`default_nettype wire

//--- logic/fetch_pc.sv
`timescale 1ns/1ps
`default_nettype none

// fetch pc register and everything derived straight from it
module fetch_pc
  import fetch_pkg::*;
#(
  parameter addr_t reset_pc = '0 // first fetch address out of reset
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  get_next_inst, // back end takes a group this cycle
  input  logic                  imem_valid,    // memory word is good
  input  logic                  rollback_en,   // back end redirect
  input  addr_t                 rollback_pc,
  input  addr_t                 next_pc,       // from fetch_steer
  output addr_t                 imem_addr,     // 8-byte aligned
  output addr_t                 cur_pc,
  output addr_t [num_slots-1:0] slot_pc,
  output addr_t [num_slots-1:0] slot_npc,
  output addr_t                 seq_pc,        // next group when nothing is taken
  output slot_vec_t             raw_valid      // validity before prediction
);

  addr_t pc_reg;     // pc being fetched now
  logic  odd_half;   // pc points at the upper word of the fetch line
  logic  pc_advance; // group accepted by the back end

  //////////////////////////////
  // pc register
  //////////////////////////////

  assign pc_advance = imem_valid && get_next_inst;

  // rollback wins over a stall and over any predicted redirect
  always_ff @(posedge clock)
  begin
    if (reset)
      pc_reg <= reset_pc;
    else if (rollback_en)
      pc_reg <= rollback_pc;
    else if (pc_advance)
      pc_reg <= next_pc;
  end

  //////////////////////////////
  // derived addresses
  //////////////////////////////

  assign cur_pc    = pc_reg;
  assign odd_half  = pc_reg[slot_sel_bit];
  assign imem_addr = {pc_reg[addr_bits-1:fetch_off_bits], {fetch_off_bits{1'b0}}};

  // at an odd word slot 0 has nothing behind it, so both slots name pc_reg
  assign slot_pc[0] = pc_reg;
  assign slot_pc[1] = odd_half ? pc_reg : pc_reg + addr_t'(inst_bytes);

  always_comb
  begin
    for (int s = 0; s < num_slots; s++)
      slot_npc[s] = slot_pc[s] + addr_t'(inst_bytes); // fall through of each slot
  end

  // half group step at an odd word, full step otherwise
  assign seq_pc = pc_reg + (odd_half ? addr_t'(inst_bytes) : addr_t'(fetch_bytes));

  // slot 0 only exists when the pc sits on the fetch boundary
  assign raw_valid[0] = imem_valid && !odd_half;
  assign raw_valid[1] = imem_valid;

endmodule

`default_nettype wire

//--- logic/predict_pkg.sv
`default_nettype none

// predictor state definitions
package predict_pkg;

  import fetch_pkg::*;

  //////////////////////////////
  // bimodal counters
  //////////////////////////////

  typedef logic [1:0] ctr_t; // 2-bit saturating counter

  localparam ctr_t ctr_strong_nt = 2'b00; // floor of the counter
  localparam ctr_t ctr_weak_nt   = 2'b01; // reset value
  localparam ctr_t ctr_strong_t  = 2'b11; // ceiling of the counter

  localparam int unsigned ctr_taken_bit = 1; // upper bit set means predict taken

  // both tables index from the first bit above the instruction offset
  localparam int unsigned pc_index_lsb = slot_sel_bit;

  //////////////////////////////
  // branch target buffer
  //////////////////////////////

  // tag is the pc shifted past the buffer index, zero filled at the top,
  // so it keeps the full address width whatever the index size is
  typedef struct packed {
    logic  valid;  // entry written by a taken resolve
    addr_t tag;    // upper pc bits
    addr_t target; // resolved branch target
  } btb_entry_t;

endpackage

`default_nettype wire

//--- logic/fetch_pkg.sv
`default_nettype none

// fetch side definitions shared by the front end blocks
package fetch_pkg;

  //////////////////////////////
  // group geometry
  //////////////////////////////

  localparam int unsigned num_slots = 2;                       // 2-wide superscalar fetch
  localparam int unsigned inst_bits = 32;                      // one instruction word
  localparam int unsigned addr_bits = 64;                      // byte address width

  localparam int unsigned inst_bytes  = inst_bits / 8;         // 4 bytes per instruction
  localparam int unsigned fetch_bytes = num_slots * inst_bytes; // 8 bytes per fetch word

  // slot helpers
  localparam int unsigned fetch_off_bits = $clog2(fetch_bytes); // low bits cleared for imem
  localparam int unsigned slot_sel_bit   = $clog2(inst_bytes);  // pc bit picking the half

  //////////////////////////////
  // types
  //////////////////////////////

  typedef logic [addr_bits-1:0]     addr_t;       // byte address
  typedef logic [inst_bits-1:0]     inst_t;       // instruction word
  typedef logic [num_slots-1:0]     slot_vec_t;   // one bit per slot
  typedef logic [fetch_bytes*8-1:0] fetch_word_t; // raw word from instruction memory

  // alpha style nop, shown on any slot that carries nothing
  localparam inst_t noop_inst = 32'h47ff_041f;

endpackage

`default_nettype wire
